// ==== bench/tb_user_io.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "user_io_defines.svh"

module tb_user_io;

	localparam int STRLEN   = `USER_IO_CONF_STRLEN;
	// clk_sys cycles per spi_clk half period, 320 ns spi_clk
	localparam int HALF_SPI = 4;
	localparam int WAIT_MAX = 4000;

	logic                clk_sys;
	logic                SPI_SS_IO;
	logic                spi_clk;
	logic                spi_mosi;
	logic [8*STRLEN-1:0] conf_str;
	logic                spi_miso;
	logic [1:0]          buttons;
	logic [1:0]          switches;
	logic                scandoubler_disable;
	logic                ypbpr;
	logic [31:0]         joystick_0;
	logic [31:0]         joystick_1;
	logic [31:0]         status;
	logic [8:0]          mouse_x;
	logic [8:0]          mouse_y;
	logic [7:0]          mouse_flags;
	logic                mouse_strobe;
	logic                ps2_kbd_clk;
	logic                ps2_kbd_data;
	logic                ps2_mouse_clk;
	logic                ps2_mouse_data;

	integer seed;
	int     errors;
	int     frames_seen;
	int     strobe_cnt;
	logic   checks_on;
	// register checks pause while a transaction may be changing outputs
	logic   regs_stable;
	logic   sw_armed;
	logic   joy0_armed;
	logic   joy1_armed;
	logic   stat_armed;

	logic [1:0]  exp_buttons;
	logic [1:0]  exp_switches;
	logic        exp_sd;
	logic        exp_ypbpr;
	logic [31:0] exp_joy0;
	logic [31:0] exp_joy1;
	logic [31:0] exp_status;
	logic [7:0]  exp_mflags;
	logic [8:0]  exp_mx;
	logic [8:0]  exp_my;

	logic [7:0] tx_buf [32];
	logic [7:0] rx_buf [32];
	string      conf_text;

	// bytes still due on each ps2 channel, in push order
	logic [7:0] kbd_q [$];
	logic [7:0] mouse_q [$];
	int         kbd_pend;
	int         mouse_pend;
	// index 0 keyboard, 1 mouse
	logic        prev_clk [2];
	int          fall_cnt [2];
	logic [10:0] frame_bits [2];
	// clk_sys cycles the ps2 clock has been high since its last fall
	int          high_len [2];

	user_io_top u_dut (
		.clk_sys             (clk_sys),
		.SPI_SS_IO           (SPI_SS_IO),
		.spi_clk             (spi_clk),
		.spi_mosi            (spi_mosi),
		.spi_miso            (spi_miso),
		.conf_str            (conf_str),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.mouse_x             (mouse_x),
		.mouse_y             (mouse_y),
		.mouse_flags         (mouse_flags),
		.mouse_strobe        (mouse_strobe),
		.ps2_kbd_clk         (ps2_kbd_clk),
		.ps2_kbd_data        (ps2_kbd_data),
		.ps2_mouse_clk       (ps2_mouse_clk),
		.ps2_mouse_data      (ps2_mouse_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] t=%0t %s", $time, msg);
	endtask

	task automatic abort_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Done: errors found");
		$finish;
	endtask

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// mode 0 master, mosi and miso msb first
	// miso is read just before each rising spi_clk edge
	task automatic spi_transfer(input int n);
		int i;
		int b;
		@(posedge clk_sys);
		regs_stable <= 1'b0;
		SPI_SS_IO   <= 1'b0;
		repeat (HALF_SPI) @(posedge clk_sys);
		for (i = 0; i < n; i++) begin
			for (b = 7; b >= 0; b--) begin
				spi_mosi <= tx_buf[i][b];
				spi_clk  <= 1'b0;
				repeat (HALF_SPI) @(posedge clk_sys);
				rx_buf[i][b] = spi_miso;
				spi_clk <= 1'b1;
				repeat (HALF_SPI) @(posedge clk_sys);
			end
		end
		spi_clk <= 1'b0;
		repeat (HALF_SPI) @(posedge clk_sys);
		SPI_SS_IO <= 1'b1;
		// deselect has to pass the decoder synchronizer
		repeat (2*HALF_SPI) @(posedge clk_sys);
		assert (rx_buf[0] == `USER_IO_CORE_TYPE)
			else report_error($sformatf("first byte %02h, core type %02h expected",
				rx_buf[0], `USER_IO_CORE_TYPE));
	endtask

	// expected values were set on the previous edge
	task automatic arm_regs();
		@(posedge clk_sys);
		regs_stable <= 1'b1;
	endtask

	// command plus 4 random data bytes, word is the little-endian result
	task automatic send_word_cmd(input logic [7:0] cmd, output logic [31:0] word);
		int i;
		tx_buf[0] = cmd;
		for (i = 1; i <= 4; i++)
			tx_buf[i] = rand_byte();
		spi_transfer(5);
		word = {tx_buf[4], tx_buf[3], tx_buf[2], tx_buf[1]};
	endtask

	task automatic wait_strobes(input int target);
		int n;
		n = 0;
		while (strobe_cnt < target && n < WAIT_MAX) begin
			@(posedge clk_sys);
			n++;
		end
		if (strobe_cnt < target)
			abort_timeout("mouse_strobe");
	endtask

	task automatic wait_ps2_done();
		int n;
		n = 0;
		while ((kbd_pend != 0 || mouse_pend != 0) && n < WAIT_MAX) begin
			@(posedge clk_sys);
			n++;
		end
		if (kbd_pend != 0 || mouse_pend != 0)
			abort_timeout("the remaining ps2 frames");
	endtask

	task automatic check_frame(input int ch);
		logic [10:0] f;
		logic [7:0]  want;
		logic        have;
		f    = frame_bits[ch];
		want = 8'h00;
		have = 1'b0;
		if (ch == 0 && kbd_q.size() != 0) begin
			want = kbd_q.pop_front();
			have = 1'b1;
			kbd_pend--;
		end else if (ch == 1 && mouse_q.size() != 0) begin
			want = mouse_q.pop_front();
			have = 1'b1;
			mouse_pend--;
		end
		frames_seen++;
		assert (have) else report_error($sformatf("ps2 ch%0d frame with no byte pushed", ch));
		assert (f[0] == 1'b0) else report_error($sformatf("ps2 ch%0d start bit is 1", ch));
		// bit 1 carries data bit 0
		assert (f[8:1] == want)
			else report_error($sformatf("ps2 ch%0d data %02h, expected %02h", ch, f[8:1], want));
		assert (^f[9:1] == 1'b1) else report_error($sformatf("ps2 ch%0d parity not odd", ch));
		assert (f[10] == 1'b1) else report_error($sformatf("ps2 ch%0d stop bit is 0", ch));
	endtask

	// frame bits are taken at falling ps2 clock edges
	// a frame is closed by the rise after its 11th fall
	task automatic watch_ps2(input int ch, input logic c, input logic d);
		if (prev_clk[ch] && !c) begin
			// idle gap before a start bit is longer than a half period in a frame
			if (fall_cnt[ch] == 0)
				assert (high_len[ch] > `USER_IO_PS2_DIV + 1)
					else report_error($sformatf("ps2 ch%0d clock not idle high between frames",
						ch));
			if (fall_cnt[ch] < 11)
				frame_bits[ch][fall_cnt[ch]] = d;
			fall_cnt[ch] = fall_cnt[ch] + 1;
			high_len[ch] = 0;
		end else if (!prev_clk[ch] && c && fall_cnt[ch] >= 11) begin
			check_frame(ch);
			fall_cnt[ch] = 0;
		end
		if (c)
			high_len[ch] = high_len[ch] + 1;
		prev_clk[ch] = c;
	endtask

	always @(posedge clk_sys) begin
		if (checks_on) begin
			watch_ps2(0, ps2_kbd_clk, ps2_kbd_data);
			watch_ps2(1, ps2_mouse_clk, ps2_mouse_data);
		end
	end

	always @(posedge clk_sys) begin
		if (checks_on && mouse_strobe)
			strobe_cnt <= strobe_cnt + 1;
	end

	a_switch_regs: assert property (@(posedge clk_sys) disable iff (!regs_stable || !sw_armed)
		buttons == exp_buttons && switches == exp_switches
		&& scandoubler_disable == exp_sd && ypbpr == exp_ypbpr)
		else report_error($sformatf("buttons %b switches %b sd %b ypbpr %b, expected %b %b %b %b",
			buttons, switches, scandoubler_disable, ypbpr,
			exp_buttons, exp_switches, exp_sd, exp_ypbpr));

	a_joy0: assert property (@(posedge clk_sys) disable iff (!regs_stable || !joy0_armed)
		joystick_0 == exp_joy0)
		else report_error($sformatf("joystick_0 %08h, expected %08h", joystick_0, exp_joy0));

	a_joy1: assert property (@(posedge clk_sys) disable iff (!regs_stable || !joy1_armed)
		joystick_1 == exp_joy1)
		else report_error($sformatf("joystick_1 %08h, expected %08h", joystick_1, exp_joy1));

	a_status: assert property (@(posedge clk_sys) disable iff (!regs_stable || !stat_armed)
		status == exp_status)
		else report_error($sformatf("status %08h, expected %08h", status, exp_status));

	a_mouse_packet: assert property (@(posedge clk_sys) disable iff (!checks_on)
		mouse_strobe |-> (mouse_flags == exp_mflags && mouse_x == exp_mx && mouse_y == exp_my))
		else report_error($sformatf("mouse flags %02h x %03h y %03h, expected %02h %03h %03h",
			mouse_flags, mouse_x, mouse_y, exp_mflags, exp_mx, exp_my));

	// nothing queued means both lines rest high
	a_kbd_idle_high: assert property (@(posedge clk_sys) disable iff (!checks_on)
		(kbd_pend == 0) |-> (ps2_kbd_clk && ps2_kbd_data))
		else report_error("keyboard ps2 lines not high with no frame due");

	a_mouse_idle_high: assert property (@(posedge clk_sys) disable iff (!checks_on)
		(mouse_pend == 0) |-> (ps2_mouse_clk && ps2_mouse_data))
		else report_error("mouse ps2 lines not high with no frame due");

	initial begin
		int                  i;
		int                  round;
		logic [7:0]          b1;
		logic [7:0]          b2;
		logic [7:0]          b3;
		logic [7:0]          want;
		logic [31:0]         w;
		logic [8*STRLEN-1:0] conf_bits;

		seed        = 32'h90ec_7337;
		errors      = 0;
		frames_seen = 0;
		strobe_cnt  = 0;
		kbd_pend    = 0;
		mouse_pend  = 0;
		prev_clk[0] = 1'b1;
		prev_clk[1] = 1'b1;
		fall_cnt[0] = 0;
		fall_cnt[1] = 0;
		high_len[0] = 0;
		high_len[1] = 0;
		checks_on   = 1'b0;
		regs_stable = 1'b0;
		sw_armed    = 1'b0;
		joy0_armed  = 1'b0;
		joy1_armed  = 1'b0;
		stat_armed  = 1'b0;

		// leftmost character goes in the top byte
		conf_text = "C64IO;O2,Video;V";
		for (i = 0; i < STRLEN; i++)
			conf_bits[8*(STRLEN-1-i) +: 8] = conf_text[i];

		SPI_SS_IO <= 1'b1;
		spi_clk   <= 1'b0;
		spi_mosi  <= 1'b0;
		conf_str  <= conf_bits;
		repeat (4) @(posedge clk_sys);
		assert (spi_miso == 1'b1 && mouse_strobe == 1'b0
			&& ps2_kbd_clk == 1'b1 && ps2_kbd_data == 1'b1
			&& ps2_mouse_clk == 1'b1 && ps2_mouse_data == 1'b1)
			else report_error("outputs not at idle levels after reset");
		checks_on <= 1'b1;

		// probe with no command, also clears the decoder byte count
		tx_buf[0] = 8'h00;
		tx_buf[1] = 8'h00;
		spi_transfer(2);

		// string characters, then zeros past its end
		tx_buf[0] = user_io_pkg::cmd_conf_read;
		for (i = 1; i < STRLEN + 2; i++)
			tx_buf[i] = 8'h00;
		spi_transfer(STRLEN + 2);
		for (i = 1; i < STRLEN + 2; i++) begin
			want = (i <= STRLEN) ? conf_text[i-1] : 8'h00;
			assert (rx_buf[i] == want)
				else report_error($sformatf("conf byte %0d is %02h, expected %02h",
					i - 1, rx_buf[i], want));
		end
		arm_regs();

		for (round = 0; round < 3; round++) begin
			b1        = rand_byte();
			tx_buf[0] = user_io_pkg::cmd_buttons;
			tx_buf[1] = b1;
			spi_transfer(2);
			exp_buttons  <= b1[1:0];
			exp_switches <= b1[3:2];
			exp_sd       <= b1[4];
			exp_ypbpr    <= b1[5];
			sw_armed     <= 1'b1;
			arm_regs();

			send_word_cmd(user_io_pkg::cmd_joy0, w);
			exp_joy0   <= w;
			joy0_armed <= 1'b1;
			arm_regs();

			send_word_cmd(user_io_pkg::cmd_joy1, w);
			exp_joy1   <= w;
			joy1_armed <= 1'b1;
			arm_regs();

			send_word_cmd(user_io_pkg::cmd_status32, w);
			exp_status <= w;
			stat_armed <= 1'b1;
			arm_regs();

			// 8-bit status clears the upper bytes
			b1        = rand_byte();
			tx_buf[0] = user_io_pkg::cmd_status8;
			tx_buf[1] = b1;
			spi_transfer(2);
			exp_status <= {24'd0, b1};
			arm_regs();
		end

		// two mouse packets, flags bits 4 and 5 extend x and y
		for (round = 0; round < 2; round++) begin
			b1 = rand_byte();
			b2 = rand_byte();
			b3 = rand_byte();
			exp_mflags <= b1;
			exp_mx     <= {b1[4], b2};
			exp_my     <= {b1[5], b3};
			mouse_q.push_back(b1);
			mouse_q.push_back(b2);
			mouse_q.push_back(b3);
			mouse_pend = mouse_pend + 3;
			tx_buf[0]  = user_io_pkg::cmd_mouse;
			tx_buf[1]  = b1;
			tx_buf[2]  = b2;
			tx_buf[3]  = b3;
			spi_transfer(4);
			wait_strobes(round + 1);
			assert (strobe_cnt == round + 1)
				else report_error($sformatf("%0d mouse strobes, expected %0d",
					strobe_cnt, round + 1));
			arm_regs();
		end

		tx_buf[0] = user_io_pkg::cmd_keyboard;
		for (i = 1; i <= 4; i++) begin
			tx_buf[i] = rand_byte();
			kbd_q.push_back(tx_buf[i]);
		end
		kbd_pend = kbd_pend + 4;
		spi_transfer(5);
		arm_regs();

		wait_ps2_done();
		repeat (2*HALF_SPI) @(posedge clk_sys);
		assert (strobe_cnt == 2)
			else report_error($sformatf("%0d mouse strobes in total, expected 2", strobe_cnt));

		$display("ps2 frames: %0d, mouse strobes: %0d, errors: %0d",
			frames_seen, strobe_cnt, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/io_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_cmd_decoder (
	input  wire         clk_sys,
	input  wire  [7:0]  rx_byte,
	input  wire         rx_toggle,
	input  wire         xfer_active,
	output logic [1:0]  buttons,
	output logic [1:0]  switches,
	output logic        scandoubler_disable,
	output logic        ypbpr,
	output logic [31:0] joystick_0,
	output logic [31:0] joystick_1,
	output logic [31:0] status,
	output logic [8:0]  mouse_x,
	output logic [8:0]  mouse_y,
	output logic [7:0]  mouse_flags,
	output logic        mouse_strobe,
	output logic        kbd_push,
	output logic        mouse_push,
	output logic [7:0]  push_byte
);

	// two synchronizer flops plus one edge register per signal
	logic tog_meta;
	logic tog_sync;
	logic tog_prev;
	logic act_meta;
	logic act_sync;
	logic act_prev;

	logic byte_evt;
	logic xfer_end;

	// byte index within the transaction, 0 is the command
	logic [2:0] byte_cnt;
	user_io_pkg::io_cmd_e acmd;

	// buttons, switches and video mode bits
	logic [5:0] but_sw;

	// first two mouse bytes wait here for the third
	logic [7:0] mouse_flags_r;
	logic [7:0] mouse_x_r;

	assign byte_evt = tog_sync ^ tog_prev;
	assign xfer_end = act_prev & ~act_sync;

	assign buttons             = but_sw[1:0];
	assign switches            = but_sw[3:2];
	assign scandoubler_disable = but_sw[4];
	assign ypbpr               = but_sw[5];

	always_ff @(posedge clk_sys) begin
		tog_meta <= rx_toggle;
		tog_sync <= tog_meta;
		tog_prev <= tog_sync;
		act_meta <= xfer_active;
		act_sync <= act_meta;
		act_prev <= act_sync;
	end

	always_ff @(posedge clk_sys) begin
		// strobes last one cycle
		mouse_strobe <= 1'b0;
		kbd_push     <= 1'b0;
		mouse_push   <= 1'b0;

		if (byte_evt) begin
			push_byte <= rx_byte;
			if (byte_cnt != 3'd7)
				byte_cnt <= byte_cnt + 3'd1;

			if (byte_cnt == 3'd0) begin
				acmd <= user_io_pkg::io_cmd_e'(rx_byte);
			end else begin
				case (acmd)
					user_io_pkg::cmd_buttons:
						but_sw <= rx_byte[5:0];
					// data bytes 1..4 fill the word from the low byte up
					user_io_pkg::cmd_joy0:
						if (byte_cnt < 3'd5)
							joystick_0[8*(byte_cnt-3'd1) +: 8] <= rx_byte;
					user_io_pkg::cmd_joy1:
						if (byte_cnt < 3'd5)
							joystick_1[8*(byte_cnt-3'd1) +: 8] <= rx_byte;
					user_io_pkg::cmd_status8:
						status <= {24'd0, rx_byte};
					user_io_pkg::cmd_status32:
						if (byte_cnt < 3'd5)
							status[8*(byte_cnt-3'd1) +: 8] <= rx_byte;
					user_io_pkg::cmd_mouse: begin
						mouse_push <= 1'b1;
						if (byte_cnt == 3'd1) begin
							mouse_flags_r <= rx_byte;
						end else if (byte_cnt == 3'd2) begin
							mouse_x_r <= rx_byte;
						end else if (byte_cnt == 3'd3) begin
							// flags 4 and 5 are the sign bits of dx and dy
							mouse_flags  <= mouse_flags_r;
							mouse_x      <= {mouse_flags_r[4], mouse_x_r};
							mouse_y      <= {mouse_flags_r[5], rx_byte};
							mouse_strobe <= 1'b1;
						end
					end
					user_io_pkg::cmd_keyboard:
						kbd_push <= 1'b1;
					default: ;
				endcase
			end
		end

		// deselect restarts the count, a last byte in the same cycle still lands
		if (xfer_end)
			byte_cnt <= 3'd0;
	end

	a_mouse_strobe_single: assert property (
		@(posedge clk_sys) mouse_strobe |=> !mouse_strobe
	);

	// only one ps2 channel takes a given byte
	a_push_exclusive: assert property (
		@(posedge clk_sys) !(kbd_push && mouse_push)
	);

endmodule

`default_nettype wire

// ==== design/ps2_tx_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "user_io_defines.svh"

module ps2_tx_channel (
	input  wire       clk_sys,
	input  wire       SPI_SS_IO,
	input  wire       push,
	input  wire [7:0] push_byte,
	output logic      ps2_clk,
	output logic      ps2_data
);

	localparam int FB    = `USER_IO_PS2_FIFO_BITS;
	localparam int DEPTH = 1 << FB;
	localparam int DIV   = `USER_IO_PS2_DIV;

	// low for the first clk_sys cycle after power-up only
	logic por_done = 1'b0;
	// select line clears the serializer in the power-up window
	// afterwards a deselected link is the normal idle state and frames keep going
	logic ser_rst;

	logic [15:0] div_cnt;
	logic        clk_div;
	logic        rise_tick;

	// one extra pointer bit tells full from empty
	logic [7:0]  fifo_mem [DEPTH];
	logic [FB:0] wptr;
	logic [FB:0] rptr;
	logic        fifo_empty;
	logic        fifo_full;
	logic        pop;

	user_io_pkg::ps2_tx_state_e state;
	logic [2:0] bit_cnt;
	logic [7:0] tx_byte;
	logic       parity_bit;

	assign ser_rst    = SPI_SS_IO & ~por_done;
	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[FB] != rptr[FB]) && (wptr[FB-1:0] == rptr[FB-1:0]);
	// last clk_sys cycle of a low half period
	assign rise_tick  = por_done && (div_cnt == 16'(DIV)) && !clk_div;
	assign pop        = rise_tick && (state == user_io_pkg::tx_idle) && !fifo_empty;
	// clock held high between frames
	assign ps2_clk    = clk_div | (state == user_io_pkg::tx_idle);

	always_ff @(posedge clk_sys) begin
		por_done <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (!por_done) begin
			div_cnt <= 16'd0;
			clk_div <= 1'b1;
		end else if (div_cnt == 16'(DIV)) begin
			div_cnt <= 16'd0;
			clk_div <= ~clk_div;
		end else begin
			div_cnt <= div_cnt + 16'd1;
		end
	end

	// pointers survive deselect so a queued packet still goes out
	always_ff @(posedge clk_sys) begin
		if (!por_done) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push && !fifo_full)
				wptr <= wptr + 1'b1;
			if (pop)
				rptr <= rptr + 1'b1;
		end
	end

	// bytes pushed into a full fifo are dropped
	always_ff @(posedge clk_sys) begin
		if (push && !fifo_full)
			fifo_mem[wptr[FB-1:0]] <= push_byte;
	end

	always_ff @(posedge clk_sys) begin
		if (pop) begin
			tx_byte    <= fifo_mem[rptr[FB-1:0]];
			// odd parity over the data bits
			parity_bit <= ~^fifo_mem[rptr[FB-1:0]];
		end
	end

	// data changes with the rising ps2 clock, device samples on the falling one
	always_ff @(posedge clk_sys or posedge ser_rst) begin
		if (ser_rst) begin
			state    <= user_io_pkg::tx_idle;
			bit_cnt  <= 3'd0;
			ps2_data <= 1'b1;
		end else if (rise_tick) begin
			case (state)
				user_io_pkg::tx_idle:
					if (!fifo_empty) begin
						ps2_data <= 1'b0;
						state    <= user_io_pkg::tx_start;
					end
				user_io_pkg::tx_start: begin
					ps2_data <= tx_byte[0];
					bit_cnt  <= 3'd0;
					state    <= user_io_pkg::tx_data;
				end
				user_io_pkg::tx_data:
					if (bit_cnt == 3'd7) begin
						ps2_data <= parity_bit;
						state    <= user_io_pkg::tx_parity;
					end else begin
						// bit_cnt is the bit already on the line
						ps2_data <= tx_byte[bit_cnt + 3'd1];
						bit_cnt  <= bit_cnt + 3'd1;
					end
				user_io_pkg::tx_parity: begin
					ps2_data <= 1'b1;
					state    <= user_io_pkg::tx_stop;
				end
				default:
					state <= user_io_pkg::tx_idle;
			endcase
		end
	end

	// both lines rest high whenever no frame is on the wire
	a_idle_lines_high: assert property (
		@(posedge clk_sys) disable iff (!por_done)
		(state == user_io_pkg::tx_idle) |-> (ps2_clk && ps2_data)
	);

	a_no_pop_empty: assert property (
		@(posedge clk_sys) disable iff (!por_done)
		pop |-> (wptr != rptr)
	);

endmodule

`default_nettype wire

// ==== design/spi_byte_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "user_io_defines.svh"

module spi_byte_engine (
	input  wire                              spi_clk,
	input  wire                              SPI_SS_IO,
	input  wire                              spi_mosi,
	input  wire [8*`USER_IO_CONF_STRLEN-1:0] conf_str,
	output logic                             spi_miso,
	output logic [7:0]                       rx_byte,
	output logic                             rx_toggle,
	output logic                             xfer_active
);

	localparam int STRLEN = `USER_IO_CONF_STRLEN;

	// bit 0..7 within a byte, byte index within the transaction
	logic [2:0] bit_cnt;
	logic [7:0] byte_cnt;

	// first 7 mosi bits of the current byte
	logic [6:0] sbuf;
	logic [7:0] mosi_byte;

	// command of the running transaction
	user_io_pkg::io_cmd_e cmd;
	// command that selects the next response byte
	logic [7:0] resp_cmd;

	// response byte being shifted out on miso
	logic [7:0] tx_byte;

	// byte toggle towards clk_sys
	// it must survive deselect, otherwise the decoder would see a phantom byte
	logic toggle_q = 1'b0;

	// the eighth bit is still on the mosi pin at the last rising edge
	assign mosi_byte = {sbuf, spi_mosi};
	assign rx_toggle = toggle_q;

	// byte 0 is the command itself, later bytes follow the latched one
	always_comb begin
		if (byte_cnt == 8'd0)
			resp_cmd = mosi_byte;
		else
			resp_cmd = cmd;
	end

	// bit and byte counters, restart with every select
	always_ff @(posedge spi_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt     <= 3'd0;
			byte_cnt    <= 8'd0;
			xfer_active <= 1'b0;
		end else begin
			xfer_active <= 1'b1;
			bit_cnt     <= bit_cnt + 3'd1;
			// saturate, long transactions only read zeros anyway
			if (bit_cnt == 3'd7 && byte_cnt != 8'hff)
				byte_cnt <= byte_cnt + 8'd1;
		end
	end

	// mosi byte assembly and command capture
	always_ff @(posedge spi_clk) begin
		if (bit_cnt != 3'd7) begin
			sbuf <= {sbuf[5:0], spi_mosi};
		end else begin
			rx_byte <= mosi_byte;
			if (byte_cnt == 8'd0)
				cmd <= user_io_pkg::io_cmd_e'(mosi_byte);
		end
	end

	// one flip per completed byte
	// rx_byte is already valid when the flip reaches clk_sys
	always_ff @(posedge spi_clk) begin
		if (bit_cnt == 3'd7)
			toggle_q <= ~toggle_q;
	end

	// next response byte is chosen at the last bit of the current one
	always_ff @(posedge spi_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tx_byte <= `USER_IO_CORE_TYPE;
		end else if (bit_cnt == 3'd7) begin
			tx_byte <= 8'd0;
			// conf byte n goes out during mosi byte n+1
			// leftmost character sits in the top byte of conf_str
			if (resp_cmd == user_io_pkg::cmd_conf_read && int'(byte_cnt) < STRLEN)
				tx_byte <= conf_str[8*(STRLEN-1-int'(byte_cnt)) +: 8];
		end
	end

	// miso changes on the falling edge, msb first
	// bit 7 of the first byte is the idle high level, the rest follows bit_cnt
	always_ff @(negedge spi_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			spi_miso <= 1'b1;
		else
			spi_miso <= tx_byte[~bit_cnt];
	end

	// a deselected link never keeps a partial byte count
	a_bit_cnt_idle: assert property (
		@(negedge spi_clk) SPI_SS_IO |-> (bit_cnt == 3'd0)
	);

endmodule

`default_nettype wire

// ==== design/user_io_defines.svh ====
`ifndef USER_IO_DEFINES_SVH
`define USER_IO_DEFINES_SVH

// configuration string length in bytes
// conf_str on the top level is 8 times this wide
`define USER_IO_CONF_STRLEN 16

// clk_sys cycles per half period of the ps2 clock, minus one
// with a 40 ns clk_sys this gives a 320 ns ps2 clock period
`define USER_IO_PS2_DIV 3

// ps2 fifo depth exponent, 8 entries per channel
`define USER_IO_PS2_FIFO_BITS 3

// core type byte returned first after every select
// a4 marks an 8-bit core
// its msb is 1, which matches the idle level of miso
`define USER_IO_CORE_TYPE 8'hA4

`endif

// ==== design/user_io_pkg.sv ====
`default_nettype none

package user_io_pkg;

	// command byte sent by the io controller as byte 0 of a transaction
	typedef enum logic [7:0] {
		cmd_buttons   = 8'h01,
		cmd_mouse     = 8'h04,
		cmd_keyboard  = 8'h05,
		cmd_conf_read = 8'h14,
		cmd_status8   = 8'h15,
		cmd_status32  = 8'h1e,
		cmd_joy0      = 8'h60,
		cmd_joy1      = 8'h61
	} io_cmd_e;

	// ps2 frame serializer
	// start bit, 8 data bits lsb first, odd parity, stop bit
	typedef enum logic [2:0] {
		tx_idle   = 3'd0,
		tx_start  = 3'd1,
		tx_data   = 3'd2,
		tx_parity = 3'd3,
		tx_stop   = 3'd4
	} ps2_tx_state_e;

endpackage

`default_nettype wire

// ==== design/user_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "user_io_defines.svh"

module user_io_top (
	input  wire                              clk_sys,
	input  wire                              SPI_SS_IO,
	input  wire                              spi_clk,
	input  wire                              spi_mosi,
	output logic                             spi_miso,
	input  wire [8*`USER_IO_CONF_STRLEN-1:0] conf_str,
	output logic [1:0]                       buttons,
	output logic [1:0]                       switches,
	output logic                             scandoubler_disable,
	output logic                             ypbpr,
	output logic [31:0]                      joystick_0,
	output logic [31:0]                      joystick_1,
	output logic [31:0]                      status,
	output logic [8:0]                       mouse_x,
	output logic [8:0]                       mouse_y,
	output logic [7:0]                       mouse_flags,
	output logic                             mouse_strobe,
	output logic                             ps2_kbd_clk,
	output logic                             ps2_kbd_data,
	output logic                             ps2_mouse_clk,
	output logic                             ps2_mouse_data
);

	// spi side to clk_sys side
	logic [7:0] rx_byte;
	logic       rx_toggle;
	logic       xfer_active;

	// decoder to ps2 channels
	logic       kbd_push;
	logic       mouse_push;
	logic [7:0] push_byte;

	spi_byte_engine u_engine (
		.spi_clk     (spi_clk),
		.SPI_SS_IO   (SPI_SS_IO),
		.spi_mosi    (spi_mosi),
		.conf_str    (conf_str),
		.spi_miso    (spi_miso),
		.rx_byte     (rx_byte),
		.rx_toggle   (rx_toggle),
		.xfer_active (xfer_active)
	);

	io_cmd_decoder u_decoder (
		.clk_sys             (clk_sys),
		.rx_byte             (rx_byte),
		.rx_toggle           (rx_toggle),
		.xfer_active         (xfer_active),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.mouse_x             (mouse_x),
		.mouse_y             (mouse_y),
		.mouse_flags         (mouse_flags),
		.mouse_strobe        (mouse_strobe),
		.kbd_push            (kbd_push),
		.mouse_push          (mouse_push),
		.push_byte           (push_byte)
	);

	ps2_tx_channel u_ps2_kbd (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.push      (kbd_push),
		.push_byte (push_byte),
		.ps2_clk   (ps2_kbd_clk),
		.ps2_data  (ps2_kbd_data)
	);

	ps2_tx_channel u_ps2_mouse (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.push      (mouse_push),
		.push_byte (push_byte),
		.ps2_clk   (ps2_mouse_clk),
		.ps2_data  (ps2_mouse_data)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the user_io testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
	--top-module tb_user_io \
	-f user_io_link.f \
	-o Vtb_user_io

./obj_dir/Vtb_user_io | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== user_io_link.f ====
+incdir+design
design/user_io_pkg.sv
design/spi_byte_engine.sv
design/io_cmd_decoder.sv
design/ps2_tx_channel.sv
design/user_io_top.sv
bench/tb_user_io.sv
